//--- design/buffer_pkg.sv
package buffer_pkg;

    typedef logic [11:0] buf_addr_t;
    typedef logic [3:0] region_idx_t;

    localparam int REGION_COUNT = 6;
    localparam buf_addr_t BASE_INIT = 12'hF00;   // No region selected yet.

    localparam buf_addr_t region_base [REGION_COUNT] = '{
        12'h000, 12'h240, 12'h480, 12'h6C0, 12'h900, 12'hB40
    };

    function automatic logic region_valid(input region_idx_t idx);
        return int'(idx) < REGION_COUNT;
    endfunction

    // Unknown regions leave the base where it was.
    function automatic buf_addr_t region_lookup(input region_idx_t idx, input buf_addr_t prev);
        if (region_valid(idx)) begin
            return region_base[idx[2:0]];
        end
        return prev;
    endfunction

endpackage

//--- design/frame_queue.sv
`timescale 1ns/1ps
`include "link_macros.svh"

module frame_queue #(
    parameter type data_t = logic [31:0],
    parameter int  DEPTH  = `LINK_QUEUE_DEPTH
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  data_t push_data,
    output logic  full,
    input  logic  pop,
    output data_t pop_data,
    output logic  empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    data_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;   // Overflow push is ignored.
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];     // Head is shown ahead of the pop.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_next(wr_ptr);
            if (do_pop) rd_ptr <= ptr_next(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- design/link_ctrl.sv
`timescale 1ns/1ps
`include "link_macros.svh"

module link_ctrl (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    cmd_empty,
    output logic                    cmd_pop,
    input  link_pkg::host_cmd_t     cmd_head,

    input  logic                    rx_empty,
    output logic                    rx_pop,
    input  link_pkg::frame_t        rx_head,

    input  logic                    tx_full,
    output logic                    tx_push,
    output link_pkg::frame_t        tx_data,

    output logic                    status_valid,
    output link_pkg::send_status_t  status,

    output logic                    deliver_valid,
    output link_pkg::frame_t        deliver_frame,
    input  logic                    deliver_ready,

    output logic                    rx_credit
);

    import link_pkg::*;
    import buffer_pkg::*;

    localparam int TIMER_W = $clog2(`LINK_TIMEOUT);
    localparam logic [3:0] RETRY_MAX = 4'(`LINK_RETRY_MAX);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SEND,      // Data frame into the tx queue.
        S_WAIT,
        S_REPLY,     // RLY after ACK or NAK.
        S_REPORT,
        S_DELIVER,
        S_ANSWER
    } state_t;

    state_t state;

    host_cmd_t cmd_r;
    frame_t rx_r;
    ptype_t ans_type;
    buf_addr_t base_r;
    logic [3:0] attempt_cnt;
    logic [TIMER_W-1:0] timer;
    logic ok_r;

    logic timeout;
    logic last_try;
    logic rx_keep;
    ptype_t rx_answer;

    assign timeout  = (timer == TIMER_W'(`LINK_TIMEOUT - 1));
    assign last_try = (attempt_cnt >= RETRY_MAX);

    // Type sort for frames taken while idle.
    always_comb begin
        rx_keep   = 1'b1;
        rx_answer = PT_ACK;
        case (rx_head.ptype)
            PT_DLINK, PT_DTYPE, PT_DTEMP, PT_DATA0, PT_DATA1: rx_answer = PT_ACK;
            PT_ERROR: rx_answer = PT_NAK;
            PT_ACK:   rx_answer = PT_RLY;
            PT_NAK:   rx_answer = PT_NAK;
            default:  rx_keep = 1'b0;   // Management types are dropped.
        endcase
    end

    //////////////////////////////////////////////////
    // Queue handshakes and outputs
    //////////////////////////////////////////////////

    assign cmd_pop = (state == S_IDLE) && !cmd_empty;
    assign rx_pop  = ((state == S_IDLE) && cmd_empty && !rx_empty) ||
                     ((state == S_WAIT) && !timeout && !rx_empty);

    always_comb begin
        tx_push = 1'b0;
        tx_data = '{ptype: PT_RLY, region: cmd_r.region, payload: '0};
        case (state)
            S_SEND: begin
                tx_push = !tx_full;
                tx_data = '{ptype: cmd_r.ptype, region: cmd_r.region, payload: cmd_r.payload};
            end
            S_REPLY: tx_push = !tx_full;
            S_ANSWER: begin
                tx_push = !tx_full;
                tx_data = '{ptype: ans_type, region: rx_r.region, payload: '0};
            end
            default: tx_push = 1'b0;
        endcase
    end

    assign status_valid  = (state == S_REPORT);
    assign status        = '{ok: ok_r, attempts: attempt_cnt, base: base_r};
    assign deliver_valid = (state == S_DELIVER);
    assign deliver_frame = rx_r;

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!cmd_empty) state <= S_SEND;   // Commands first.
                    else if (!rx_empty && rx_keep) state <= S_DELIVER;
                end
                S_SEND: if (!tx_full) state <= S_WAIT;
                S_WAIT: begin
                    if (timeout) begin
                        state <= last_try ? S_REPORT : S_SEND;
                    end else if (!rx_empty &&
                                 (rx_head.ptype == PT_ACK || rx_head.ptype == PT_NAK)) begin
                        state <= S_REPLY;
                    end
                end
                S_REPLY: begin
                    if (!tx_full) state <= (ok_r || last_try) ? S_REPORT : S_SEND;
                end
                S_REPORT:  state <= S_IDLE;
                S_DELIVER: if (deliver_ready) state <= S_ANSWER;
                S_ANSWER:  if (!tx_full) state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            attempt_cnt <= '0;
            timer       <= '0;
            ok_r        <= 1'b0;
        end else begin
            if (cmd_pop) begin
                attempt_cnt <= '0;
                ok_r        <= 1'b0;
            end else if (state == S_SEND && !tx_full) begin
                attempt_cnt <= attempt_cnt + 1'b1;
            end
            if (state == S_WAIT && rx_pop && rx_head.ptype == PT_ACK) ok_r <= 1'b1;
            // Runs from the push cycle onward.
            if (state == S_WAIT) timer <= timer + 1'b1;
            else timer <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) base_r <= BASE_INIT;
        else if (cmd_pop) base_r <= region_lookup(cmd_head.region, base_r);
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) cmd_r <= cmd_head;
        if (rx_pop) begin
            rx_r     <= rx_head;
            ans_type <= rx_answer;
        end
    end

    // One credit back per released rx slot.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) rx_credit <= 1'b0;
        else rx_credit <= rx_pop;
    end

endmodule

//--- design/link_macros.svh
`ifndef LINK_MACROS_SVH
`define LINK_MACROS_SVH

// Answer wait, in clock cycles.
`define LINK_TIMEOUT 64

// Data frames sent before a transfer fails.
`define LINK_RETRY_MAX 4

`define LINK_TX_CREDITS 4   // Partner receive slots at reset.
`define LINK_QUEUE_DEPTH 4

`endif

//--- design/link_pkg.sv
package link_pkg;

    //////////////////////////////////////////////////
    // Packet types
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        PT_INIT   = 4'd0,
        PT_ACK    = 4'd1,
        PT_NAK    = 4'd2,
        PT_RLY    = 4'd3,
        PT_LINK   = 4'd4,
        PT_DIDX   = 4'd5,
        PT_DPARAM = 4'd6,
        PT_DDIDX  = 4'd7,
        PT_DLINK  = 4'd8,
        PT_DTYPE  = 4'd9,
        PT_DTEMP  = 4'd10,
        PT_DATA0  = 4'd13,
        PT_DATA1  = 4'd14,
        PT_ERROR  = 4'd15
    } ptype_t;

    //////////////////////////////////////////////////
    // Frames, commands and results
    //////////////////////////////////////////////////

    // Same layout on both link directions.
    typedef struct packed {
        ptype_t                  ptype;
        buffer_pkg::region_idx_t region;
        logic [31:0]             payload;
    } frame_t;

    typedef struct packed {
        ptype_t                  ptype;
        buffer_pkg::region_idx_t region;
        logic [31:0]             payload;
    } host_cmd_t;

    typedef struct packed {
        logic                  ok;
        logic [3:0]            attempts;   // Data frames sent.
        buffer_pkg::buf_addr_t base;
    } send_status_t;

endpackage

//--- design/link_top.sv
`timescale 1ns/1ps

module link_top (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  link_pkg::host_cmd_t     cmd,
    output logic                    status_valid,
    output link_pkg::send_status_t  status,
    output logic                    deliver_valid,
    output link_pkg::frame_t        deliver_frame,
    input  logic                    deliver_ready,

    output logic                    tx_valid,
    output link_pkg::frame_t        tx_frame,
    input  logic                    tx_credit,
    input  logic                    rx_valid,
    input  link_pkg::frame_t        rx_frame,
    output logic                    rx_credit
);

    import link_pkg::*;

    logic cmd_full;
    logic cmd_empty;
    logic cmd_pop;
    host_cmd_t cmd_head;

    logic rx_empty;
    logic rx_pop;
    frame_t rx_head;

    logic tx_full;
    logic tx_empty;
    logic tx_push;
    logic tx_pop;
    frame_t tx_data;
    frame_t tx_head;

    assign cmd_ready = !cmd_full;

    frame_queue #(.data_t(host_cmd_t)) cmd_q (
        .clk(clk), .rst(rst),
        .push(cmd_valid), .push_data(cmd), .full(cmd_full),
        .pop(cmd_pop), .pop_data(cmd_head), .empty(cmd_empty)
    );

    // Partner holds credits, so the rx queue never overflows.
    frame_queue #(.data_t(frame_t)) rx_q (
        .clk(clk), .rst(rst),
        .push(rx_valid), .push_data(rx_frame), .full(),
        .pop(rx_pop), .pop_data(rx_head), .empty(rx_empty)
    );

    frame_queue #(.data_t(frame_t)) tx_q (
        .clk(clk), .rst(rst),
        .push(tx_push), .push_data(tx_data), .full(tx_full),
        .pop(tx_pop), .pop_data(tx_head), .empty(tx_empty)
    );

    tx_credit_gate tx_gate (
        .clk(clk), .rst(rst),
        .empty(tx_empty), .pop(tx_pop), .head(tx_head),
        .tx_credit(tx_credit), .tx_valid(tx_valid), .tx_frame(tx_frame)
    );

    link_ctrl ctrl (
        .clk(clk), .rst(rst),
        .cmd_empty(cmd_empty), .cmd_pop(cmd_pop), .cmd_head(cmd_head),
        .rx_empty(rx_empty), .rx_pop(rx_pop), .rx_head(rx_head),
        .tx_full(tx_full), .tx_push(tx_push), .tx_data(tx_data),
        .status_valid(status_valid), .status(status),
        .deliver_valid(deliver_valid), .deliver_frame(deliver_frame),
        .deliver_ready(deliver_ready), .rx_credit(rx_credit)
    );

endmodule

//--- design/tx_credit_gate.sv
`timescale 1ns/1ps
`include "link_macros.svh"

module tx_credit_gate (
    input  logic              clk,
    input  logic              rst,
    input  logic              empty,
    output logic              pop,
    input  link_pkg::frame_t  head,
    input  logic              tx_credit,
    output logic              tx_valid,
    output link_pkg::frame_t  tx_frame
);

    localparam int CREDIT_W = $clog2(`LINK_TX_CREDITS + 1);
    localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`LINK_TX_CREDITS);

    logic [CREDIT_W-1:0] credits;

    // One frame per cycle and only with a credit in hand.
    assign pop = (credits != '0) && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= CREDIT_MAX;
        end else begin
            case ({tx_credit, pop})
                2'b10:   if (credits != CREDIT_MAX) credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;   // Return and spend cancel.
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) tx_valid <= 1'b0;
        else tx_valid <= pop;
    end

    always_ff @(posedge clk) begin
        if (pop) tx_frame <= head;
    end

endmodule

//--- link_top.f
+incdir+design
design/buffer_pkg.sv
design/link_pkg.sv
design/frame_queue.sv
design/tx_credit_gate.sv
design/link_ctrl.sv
design/link_top.sv
test/link_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the link_tb simulation with Verilator from the project root.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module link_tb -f link_top.f -o link_sim &&
./obj_dir/link_sim | tee /dev/stderr | grep -q "^PASS: all tests$" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

//--- test/link_cases.txt
# name kind(0 send,1 idle rx,2 credit hold) ptype region payload(kind 2: count) script
# exp_ok exp_attempts exp_base exp_deliveries exp_tx_count exp_answer_type   (hex: ptype..base, ans)
ack_region1 0 e 1 12345678 A 1 1 240 0 0 0
ack_bad_region 0 e 9 0badc0de A 1 1 240 0 0 0
nak_then_ack 0 d 2 a5a5a5a5 NTA 1 2 480 0 0 0
timeout_then_ack 0 e 3 0f0f1234 SA 1 2 6c0 0 0 0
never_answered 0 d 4 deadbeef - 0 4 900 0 0 0
nak_every_try 0 e 0 00c0ffee NNNN 0 4 000 0 0 0
ack_region5 0 d 5 cafef00d A 1 1 b40 0 0 0
rx_data0 1 d 2 11112222 - 0 0 000 1 1 1
rx_data1 1 e 3 33334444 - 0 0 000 1 1 1
rx_dlink 1 8 1 55556666 - 0 0 000 1 1 1
rx_dtype 1 9 0 77778888 - 0 0 000 1 1 1
rx_dtemp 1 a 4 9999aaaa - 0 0 000 1 1 1
rx_error 1 f 5 bbbbcccc - 0 0 000 1 1 2
rx_ack 1 1 6 00000001 - 0 0 000 1 1 3
rx_nak 1 2 7 00000002 - 0 0 000 1 1 2
rx_link_dropped 1 4 1 ddddeeee - 0 0 000 0 0 0
rx_didx_dropped 1 5 2 ffff0000 - 0 0 000 0 0 0
rx_dparam_dropped 1 6 3 01020304 - 0 0 000 0 0 0
rx_rly_dropped 1 3 4 05060708 - 0 0 000 0 0 0
credit_hold_burst 2 d 0 00000006 - 0 0 000 6 6 1
ack_after_hold 0 e f 13572468 A 1 1 b40 0 0 0

//--- test/link_tb.sv
`timescale 1ns/1ps
`include "link_macros.svh"

module link_tb;

    import link_pkg::*;
    import buffer_pkg::*;

    localparam int MAX_CASES = 32;
    localparam int STEP_LIMIT = `LINK_TIMEOUT + 20;

    logic clk;
    logic rst;
    logic cmd_valid;
    logic cmd_ready;
    host_cmd_t cmd;
    logic status_valid;
    send_status_t status;
    logic deliver_valid;
    frame_t deliver_frame;
    logic deliver_ready;
    logic tx_valid;
    frame_t tx_frame;
    logic tx_credit;
    logic rx_valid;
    frame_t rx_frame;
    logic rx_credit;

    //////////////////////////////////////////////////
    // Case table and scoreboard
    //////////////////////////////////////////////////

    string       case_name [MAX_CASES];
    int          case_kind [MAX_CASES];
    logic [3:0]  case_ptype [MAX_CASES];
    logic [3:0]  case_region [MAX_CASES];
    logic [31:0] case_payload [MAX_CASES];
    string       case_script [MAX_CASES];
    int          case_ok [MAX_CASES];
    int          case_attempts [MAX_CASES];
    buf_addr_t   case_base [MAX_CASES];
    int          case_dlv [MAX_CASES];
    int          case_ntx [MAX_CASES];
    logic [3:0]  case_ans [MAX_CASES];
    int          n_cases;

    frame_t       tx_log [$];
    send_status_t status_log [$];
    frame_t       deliver_log [$];

    int rx_sent;
    int rx_credit_seen;
    int credits_owed;      // Tx credits the partner still has to return.
    int credit_wait;
    bit withhold;
    int cycles;
    int cycle_limit;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    link_top link_top_inst (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
        .status_valid(status_valid), .status(status),
        .deliver_valid(deliver_valid), .deliver_frame(deliver_frame),
        .deliver_ready(deliver_ready),
        .tx_valid(tx_valid), .tx_frame(tx_frame), .tx_credit(tx_credit),
        .rx_valid(rx_valid), .rx_frame(rx_frame), .rx_credit(rx_credit)
    );

    always #20 clk = ~clk;

    // Outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (!rst) begin
            if (tx_valid) begin
                tx_log.push_back(tx_frame);
                credits_owed++;
            end
            if (status_valid) status_log.push_back(status);
            if (deliver_valid && deliver_ready) deliver_log.push_back(deliver_frame);
            if (rx_credit) rx_credit_seen++;
        end
    end

    // Partner credit return and host stalls.
    initial begin
        void'($urandom(41575));
        forever begin
            @(posedge clk);
            #2;
            tx_credit = 1'b0;
            deliver_ready = ($urandom % 4) != 0;
            if (!rst) begin
                if (credit_wait > 0) begin
                    credit_wait--;
                end else if (credits_owed > 0 && !withhold) begin
                    tx_credit = 1'b1;
                    credits_owed--;
                    credit_wait = $urandom % 4;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Run stopped at the cycle limit of %0d", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic next_drive_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic expect_value(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
        assert (expected === actual) else begin
            $display("Mismatch %s: expected %h, actual %h", what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s", msg);
            test_errors++;
        end
    endtask

    task automatic partner_send(input frame_t f);
        int waited;
        waited = 0;
        while (rx_sent - rx_credit_seen >= `LINK_QUEUE_DEPTH && waited < 200) begin
            next_drive_slot();
            waited++;
        end
        expect_true(waited < 200, "Partner never got a receive credit back");
        rx_valid = 1'b1;
        rx_frame = f;
        rx_sent++;
        next_drive_slot();
        rx_valid = 1'b0;
    endtask

    task automatic load_cases();
        int fd;
        int cnt;
        string line;
        string nm;
        string sc;
        int kind;
        int ok;
        int att;
        int dlv;
        int ntx;
        logic [3:0] pt;
        logic [3:0] rg;
        logic [31:0] pl;
        buf_addr_t base;
        logic [3:0] ans;
        fd = $fopen("test/link_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/link_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            cnt = $sscanf(line, "%s %d %h %h %h %s %d %d %h %d %d %h",
                          nm, kind, pt, rg, pl, sc, ok, att, base, dlv, ntx, ans);
            if (cnt != 12) begin
                $display("Case line could not be read: %s", line);
                errors++;
            end else begin
                case_name[n_cases]     = nm;
                case_kind[n_cases]     = kind;
                case_ptype[n_cases]    = pt;
                case_region[n_cases]   = rg;
                case_payload[n_cases]  = pl;
                case_script[n_cases]   = sc;
                case_ok[n_cases]       = ok;
                case_attempts[n_cases] = att;
                case_base[n_cases]     = base;
                case_dlv[n_cases]      = dlv;
                case_ntx[n_cases]      = ntx;
                case_ans[n_cases]      = ans;
                n_cases++;
            end
        end
        $fclose(fd);
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    //////////////////////////////////////////////////
    // Test kinds
    //////////////////////////////////////////////////

    task automatic send_case_test(input int i);
        frame_t data_f;
        frame_t rly_f;
        frame_t exp_tx [$];
        string script;
        int sp;
        int att;
        int seen;
        int waited;
        int tx_start;
        int st_start;
        byte c;
        bit done;
        script = (case_script[i] == "-") ? "" : case_script[i];
        data_f = '{ptype: ptype_t'(case_ptype[i]), region: case_region[i],
                   payload: case_payload[i]};
        rly_f = '{ptype: PT_RLY, region: case_region[i], payload: 32'h0};
        // Expected link traffic; a stray T never counts as an answer.
        sp = 0;
        att = 0;
        done = 0;
        while (!done) begin
            exp_tx.push_back(data_f);
            att++;
            while (sp < script.len() && script[sp] == "T") sp++;
            c = (sp < script.len()) ? script[sp] : "S";
            sp++;
            if (c == "A" || c == "N") exp_tx.push_back(rly_f);
            if (c == "A" || att == `LINK_RETRY_MAX) done = 1;
        end
        tx_start = tx_log.size();
        st_start = status_log.size();
        expect_true(cmd_ready, "Command queue refused a new command");
        cmd_valid = 1'b1;
        cmd = '{ptype: ptype_t'(case_ptype[i]), region: case_region[i],
                payload: case_payload[i]};
        next_drive_slot();
        cmd_valid = 1'b0;
        sp = 0;
        seen = tx_start;
        waited = 0;
        while (status_log.size() == st_start && waited < case_attempts[i] * STEP_LIMIT) begin
            if (tx_log.size() > seen) begin
                if (tx_log[seen].ptype == data_f.ptype) begin
                    while (sp < script.len() && script[sp] == "T") begin
                        partner_send('{ptype: PT_DTEMP, region: 4'h0, payload: 32'h5EED0000});
                        sp++;
                    end
                    if (sp < script.len()) begin
                        if (script[sp] == "A")
                            partner_send('{ptype: PT_ACK, region: case_region[i], payload: 32'h0});
                        else if (script[sp] == "N")
                            partner_send('{ptype: PT_NAK, region: case_region[i], payload: 32'h0});
                        sp++;
                    end
                end
                seen++;
            end else begin
                next_drive_slot();
                waited++;
            end
        end
        expect_true(status_log.size() > st_start, "No send status came from the DUT");
        if (status_log.size() > st_start) begin
            expect_value({case_name[i], " ok"}, 64'(case_ok[i]),
                         64'(status_log[st_start].ok));
            expect_value({case_name[i], " attempts"}, 64'(case_attempts[i]),
                         64'(status_log[st_start].attempts));
            expect_value({case_name[i], " base"}, 64'(case_base[i]),
                         64'(status_log[st_start].base));
        end
        repeat (20) next_drive_slot();
        expect_value({case_name[i], " status count"}, 64'd1,
                     64'(status_log.size() - st_start));
        expect_value({case_name[i], " tx count"}, 64'(exp_tx.size()),
                     64'(tx_log.size() - tx_start));
        for (int k = 0; k < exp_tx.size() && tx_start + k < tx_log.size(); k++) begin
            expect_value($sformatf("%s tx frame %0d", case_name[i], k),
                         64'(exp_tx[k]), 64'(tx_log[tx_start + k]));
        end
    endtask

    task automatic idle_rx_test(input int i);
        frame_t f;
        int tx_start;
        int dl_start;
        int waited;
        f = '{ptype: ptype_t'(case_ptype[i]), region: case_region[i], payload: case_payload[i]};
        tx_start = tx_log.size();
        dl_start = deliver_log.size();
        partner_send(f);
        waited = 0;
        while (case_dlv[i] != 0 && deliver_log.size() == dl_start && waited < 40) begin
            next_drive_slot();
            waited++;
        end
        repeat (20) next_drive_slot();
        if (case_dlv[i] != 0) begin
            expect_true(deliver_log.size() > dl_start, "Received frame was never delivered");
        end
        expect_value({case_name[i], " deliveries"}, 64'(case_dlv[i]),
                     64'(deliver_log.size() - dl_start));
        if (case_dlv[i] != 0 && deliver_log.size() > dl_start) begin
            expect_value({case_name[i], " delivered frame"}, 64'(f), 64'(deliver_log[dl_start]));
        end
        expect_value({case_name[i], " tx count"}, 64'(case_ntx[i]),
                     64'(tx_log.size() - tx_start));
        if (case_ntx[i] == 1 && tx_log.size() > tx_start) begin
            expect_value({case_name[i], " answer"},
                         64'({case_ans[i], case_region[i], 32'h0}), 64'(tx_log[tx_start]));
        end
    endtask

    task automatic credit_hold_test(input int i);
        int n;
        int tx_start;
        int dl_start;
        int waited;
        n = int'(case_payload[i]);
        waited = 0;
        while (credits_owed > 0 && waited < 50) begin
            next_drive_slot();
            waited++;
        end
        withhold = 1;
        tx_start = tx_log.size();
        dl_start = deliver_log.size();
        for (int k = 0; k < n; k++) begin
            partner_send('{ptype: ptype_t'(case_ptype[i]), region: 4'(k), payload: 32'(k)});
        end
        repeat (60) next_drive_slot();
        expect_value({case_name[i], " tx while held"}, 64'(`LINK_TX_CREDITS),
                     64'(tx_log.size() - tx_start));
        withhold = 0;
        waited = 0;
        while (tx_log.size() - tx_start < case_ntx[i] && waited < 200) begin
            next_drive_slot();
            waited++;
        end
        repeat (20) next_drive_slot();
        expect_value({case_name[i], " tx count"}, 64'(case_ntx[i]),
                     64'(tx_log.size() - tx_start));
        expect_value({case_name[i], " deliveries"}, 64'(case_dlv[i]),
                     64'(deliver_log.size() - dl_start));
        for (int k = 0; k < case_ntx[i] && tx_start + k < tx_log.size(); k++) begin
            expect_value($sformatf("%s tx frame %0d", case_name[i], k),
                         64'({case_ans[i], 4'(k), 32'h0}), 64'(tx_log[tx_start + k]));
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        deliver_ready = 1'b0;
        tx_credit = 1'b0;
        rx_valid = 1'b0;
        rx_frame = '0;
        withhold = 0;
        n_cases = 0;
        errors = 0;
        test_errors = 0;
        load_cases();
        cycle_limit = 200;
        for (int i = 0; i < n_cases; i++) begin
            if (case_kind[i] == 0) cycle_limit += case_attempts[i] * STEP_LIMIT;
            else if (case_kind[i] == 2) cycle_limit += int'(case_payload[i]) * STEP_LIMIT;
            else cycle_limit += STEP_LIMIT;
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        next_drive_slot();
        for (int i = 0; i < n_cases; i++) begin
            case (case_kind[i])
                0: send_case_test(i);
                1: idle_rx_test(i);
                default: credit_hold_test(i);
            endcase
            close_test(case_name[i]);
        end
        repeat (10) next_drive_slot();
        expect_value("rx_credit count", 64'(rx_sent), 64'(rx_credit_seen));
        close_test("rx_credit_count");
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
